/* sim.f */
+incdir+logic
logic/core_pkg.sv
logic/isa_pkg.sv
logic/slot_if.sv
logic/operand_stack.sv
logic/alu.sv
logic/exec_unit.sv
logic/instr_sequencer.sv
logic/s64_core.sv
bench/tb_s64_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_s64_core -o tb_s64_core_sim

./obj_dir/tb_s64_core_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    exit 1
fi

/* bench/tb_s64_core.sv */
`include "core_params.svh"

module tb_s64_core
    import core_pkg::*, isa_pkg::*;
();
    logic   clk_i;
    logic   rst_i;
    logic   ack_i;
    word_t  dat_i;
    paddr_t adr_o;
    logic   cyc_o;
    logic   we_o;
    logic   vpa_o;
    word_t  dat_o;

    word_t       mem [paddr_t];     // Sparse bus memory, one word per packet address
    paddr_t      exp_adr [$];
    word_t       exp_dat [$];
    logic [31:0] rng_state;
    logic        rst_q;
    logic        first_pending;
    logic        loop_reached;
    logic        busy;
    int          wait_left;
    paddr_t      acc_adr;
    logic        acc_we;
    word_t       acc_dat;
    paddr_t      e_adr;
    word_t       e_dat;
    word_t       pkt_word;
    int          pkt_nslots;
    int          pkt_bits;
    paddr_t      code_pa;
    paddr_t      loop_pa;
    int          pkt_total;
    int          cycles;
    int          errors;
    int          checks;
    int          tests;
    int          reset_checks;

    s64_core u_s64_core (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .ack_i(ack_i),
        .dat_i(dat_i),
        .adr_o(adr_o),
        .cyc_o(cyc_o),
        .we_o (we_o),
        .vpa_o(vpa_o),
        .dat_o(dat_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) rst_q <= rst_i;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Operand bits taken by each opcode
    function automatic int arg_bits(opcode_t op);
        case (op)
            OP_LIT8:   return 8;
            OP_LIT16:  return 16;
            OP_LIT32:  return 32;
            OP_JUMPS:  return 12;
            OP_STORES, OP_LOADS, OP_INTOPS: return 4;
            default:   return 0;
        endcase
    endfunction

    function automatic word_t sext(logic [31:0] v, int bits);
        word_t r;
        for (int i = 0; i < 64; i++)
            r[i] = (i < bits) ? v[i] : v[bits-1];
        return r;
    endfunction

    // Expected result of y op z
    function automatic word_t calc_intop(subop_t op, word_t a, word_t b);
        case (op)
            SUB_ADD:  return a + b;
            SUB_SUB:  return a - b;
            SUB_XOR:  return a ^ b;
            SUB_OR:   return a | b;
            SUB_AND:  return a & b;
            SUB_SLT:  return {63'd0, $signed(a) < $signed(b)};
            SUB_SLTU: return {63'd0, a < b};
            SUB_SEQ:  return {63'd0, a == b};
            default:  return b;
        endcase
    endfunction

    // **********************************************************
    // Bus memory with random wait states
    // **********************************************************
    always @(posedge clk_i) begin
        #2;
        if (ack_i) begin
            busy = 1'b0;
            if (acc_we)
                mem[acc_adr] = acc_dat;
        end
        ack_i = 1'b0;
        if (rst_i) begin
            busy = 1'b0;
        end else if (cyc_o) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'(lcg_next() >> 30);
            end
            if (wait_left == 0) begin
                ack_i   = 1'b1;
                acc_adr = adr_o;
                acc_we  = we_o;
                acc_dat = dat_o;
                dat_i   = mem.exists(adr_o) ? mem[adr_o] : '0;
            end else begin
                wait_left--;
            end
        end
    end

    // Bus outputs are checked mid-cycle, where they are settled
    always @(negedge clk_i) begin
        if (rst_q) begin
            assert (!cyc_o) else begin
                $display("Fail at %0t: cyc_o expected 0, got %b", $time, cyc_o);
                errors++;
            end
            first_pending = 1'b1;
        end else if (cyc_o) begin
            if (first_pending) begin
                first_pending = 1'b0;
                reset_checks++;
                assert (vpa_o) else begin
                    $display("Fail at %0t: vpa_o expected 1, got %b", $time, vpa_o);
                    errors++;
                end
                assert (adr_o == `RESET_VECTOR) else begin
                    $display("Fail at %0t: adr_o expected %h, got %h", $time,
                             `RESET_VECTOR, adr_o);
                    errors++;
                end
            end
            if (vpa_o && ack_i && adr_o == loop_pa)
                loop_reached = 1'b1;
            if (we_o && ack_i) begin
                checks++;
                if (exp_adr.size() == 0) begin
                    $display("Unexpected write of %h to address %h at %0t, none was due",
                             dat_o, adr_o, $time);
                    errors++;
                end else begin
                    e_adr = exp_adr.pop_front();
                    e_dat = exp_dat.pop_front();
                    assert (adr_o == e_adr) else begin
                        $display("Fail at %0t: adr_o expected %h, got %h", $time, e_adr, adr_o);
                        errors++;
                    end
                    assert (dat_o == e_dat) else begin
                        $display("Fail at %0t: dat_o expected %h, got %h", $time, e_dat, dat_o);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 8 * (`SLOT_MAX + 1) * 4 * pkt_total + 200) begin
            $display("Timeout after %0d cycles, the core never reached its end loop", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // **********************************************************
    // Packet assembly
    // **********************************************************
    task automatic flush_pkt();
        if (pkt_nslots == 0)
            return;
        pkt_word[63:60] = pkt_nslots[3:0];
        mem[code_pa]    = pkt_word;
        code_pa++;
        pkt_total++;
        pkt_word   = '0;
        pkt_nslots = 0;
        pkt_bits   = 0;
    endtask

    // Operands stay in bits 31:0 so they never reach the opcode slots
    task automatic add_slot(opcode_t op, logic [31:0] arg);
        int len;
        len = arg_bits(op);
        if (pkt_nslots == `SLOT_MAX || pkt_bits + len > 32)
            flush_pkt();
        pkt_nslots++;
        pkt_word[63 - 4 * pkt_nslots -: 4] = op;
        for (int i = 0; i < len; i++)
            pkt_word[pkt_bits + i] = arg[i];
        pkt_bits += len;
    endtask

    task automatic jump_slot(subop_t sub, logic [7:0] off);
        add_slot(OP_JUMPS, {20'd0, off, sub});
    endtask

    task automatic expect_write(word_t byte_addr, word_t data);
        exp_adr.push_back(byte_addr[63:3]);
        exp_dat.push_back(data);
    endtask

    task automatic store_marker(logic [7:0] marker, logic [7:0] addr);
        add_slot(OP_LIT8, marker);
        add_slot(OP_LIT8, addr);
        add_slot(OP_STORES, SUB_SDM);
    endtask

    task automatic lit_store(opcode_t op, logic [31:0] v, logic [15:0] addr);
        add_slot(op, v);
        add_slot(OP_LIT16, addr);
        add_slot(OP_STORES, SUB_SDM);
        expect_write(word_t'(addr), sext(v, arg_bits(op)));
    endtask

    task automatic loop_here();
        flush_pkt();
        loop_pa = code_pa;
        jump_slot(SUB_J8, 8'd0);
        flush_pkt();
    endtask

    // **********************************************************
    // Test sequencing
    // **********************************************************
    task automatic prepare_run();
        @(posedge clk_i);
        #1 rst_i = 1'b1;
        mem.delete();
        exp_adr.delete();
        exp_dat.delete();
        code_pa    = `RESET_VECTOR;
        pkt_word   = '0;
        pkt_nslots = 0;
        pkt_bits   = 0;
    endtask

    task automatic run_program(string name);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        repeat (10) @(posedge clk_i);
        #1 rst_i = 1'b0;
        loop_reached = 1'b0;
        while (!loop_reached)
            @(posedge clk_i);
        if (exp_adr.size() != 0) begin
            $display("Test %s ended with %0d expected writes missing", name, exp_adr.size());
            errors++;
        end
        $display("Test %s done: %0d writes checked, %0d errors", name, checks - chk0,
                 errors - err0);
        tests++;
    endtask

    task automatic literal_stores();
        prepare_run();
        lit_store(OP_LIT8, 32'hFB, 16'h100);
        lit_store(OP_LIT8, 32'h7F, 16'h108);
        lit_store(OP_LIT16, 32'h8001, 16'h110);
        lit_store(OP_LIT16, 32'h1234, 16'h118);
        lit_store(OP_LIT32, 32'h8000_0000, 16'h120);
        lit_store(OP_LIT32, 32'h1234_5678, 16'h128);
        loop_here();
        run_program("literals");
    endtask

    task automatic alu_results();
        subop_t ops [8];
        word_t  a;
        word_t  b;
        word_t  addr;
        ops = '{SUB_ADD, SUB_SUB, SUB_XOR, SUB_OR, SUB_AND, SUB_SLT, SUB_SLTU, SUB_SEQ};
        prepare_run();
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 8; i++) begin
                a    = sext(lcg_next(), 32);
                b    = (r == 1 && ops[i] == SUB_SEQ) ? a : sext(lcg_next(), 32);
                addr = 64'h200 + 64'(8 * (8 * r + i));
                add_slot(OP_LIT32, a[31:0]);
                add_slot(OP_LIT32, b[31:0]);
                add_slot(OP_INTOPS, {28'd0, ops[i]});
                add_slot(OP_LIT16, addr[31:0]);
                add_slot(OP_STORES, SUB_SDM);
                expect_write(addr, calc_intop(ops[i], a, b));
            end
        end
        loop_here();
        run_program("intops");
    endtask

    task automatic load_add();
        word_t pre;
        pre = 64'h0123_4567_89AB_CDEF;
        prepare_run();
        mem[paddr_t'(64'h400 >> 3)] = pre;
        add_slot(OP_LIT16, 32'h400);
        add_slot(OP_LOADS, SUB_LDM);
        add_slot(OP_LIT8, 32'hFD);
        add_slot(OP_INTOPS, SUB_ADD);
        add_slot(OP_LIT16, 32'h408);
        add_slot(OP_STORES, SUB_SDM);
        expect_write(64'h408, pre + sext(32'hFD, 8));
        loop_here();
        run_program("load");
    endtask

    // Each case is three packets, flag test, fall-through path, taken path
    task automatic cond_jumps();
        subop_t     sub;
        logic [7:0] flag;
        logic [7:0] addr;
        logic       taken;
        prepare_run();
        for (int c = 0; c < 4; c++) begin
            sub   = (c < 2) ? SUB_JT8 : SUB_JF8;
            flag  = (c % 2 == 0) ? 8'd0 : 8'd5;
            taken = (sub == SUB_JT8) ? (flag != 0) : (flag == 0);
            addr  = 8'h40 + 8'(8 * c);
            add_slot(OP_LIT8, flag);
            jump_slot(sub, 8'd2);
            flush_pkt();
            store_marker(8'h10 + 8'(2 * c), addr);
            jump_slot(SUB_J8, 8'd2);
            flush_pkt();
            store_marker(8'h11 + 8'(2 * c), addr);
            flush_pkt();
            expect_write(word_t'(addr), word_t'(8'h10 + 8'(2 * c) + 8'(taken)));
        end
        loop_here();
        run_program("cond_jumps");
    endtask

    task automatic call_return();
        prepare_run();
        jump_slot(SUB_CALL8, 8'd2);
        flush_pkt();
        store_marker(8'h2B, 8'h58);     // Caller resumes here
        jump_slot(SUB_J8, 8'd2);
        flush_pkt();
        store_marker(8'h2A, 8'h50);     // Subroutine
        add_slot(OP_RET, 32'd0);
        expect_write(64'h50, 64'h2A);
        expect_write(64'h58, 64'h2B);
        loop_here();
        run_program("call_ret");
    endtask

    initial begin
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        ack_i         = 1'b0;
        dat_i         = '0;
        rst_q         = 1'b1;
        first_pending = 1'b0;
        loop_reached  = 1'b0;
        busy          = 1'b0;
        wait_left     = 0;
        acc_we        = 1'b0;
        loop_pa       = '0;
        rng_state     = 32'hb0fc;
        pkt_total     = 0;
        cycles        = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        reset_checks  = 0;

        literal_stores();
        alu_results();
        load_add();
        cond_jumps();
        call_return();
        $display("Reset checked %0d times, first access after each reset inspected",
                 reset_checks);

        $display("%0d tests, %0d writes checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* logic/s64_core.sv */
module s64_core
    import core_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   ack_i,
    input  word_t  dat_i,
    output paddr_t adr_o,
    output logic   cyc_o,
    output logic   we_o,
    output logic   vpa_o,
    output word_t  dat_o
);
    slot_if slot_bus ();

    instr_sequencer u_seq (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .ack_i(ack_i),
        .dat_i(dat_i),
        .adr_o(adr_o),
        .cyc_o(cyc_o),
        .we_o (we_o),
        .vpa_o(vpa_o),
        .dat_o(dat_o),
        .slot (slot_bus.seq)
    );

    exec_unit u_exec (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .slot (slot_bus.exec)
    );

endmodule

/* logic/instr_sequencer.sv */
`include "core_params.svh"

module instr_sequencer
    import core_pkg::*, isa_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   ack_i,
    input  word_t  dat_i,
    output paddr_t adr_o,
    output logic   cyc_o,
    output logic   we_o,
    output logic   vpa_o,
    output word_t  dat_o,
    slot_if.seq    slot
);
    logic       run;        // Low during reset, so no access starts
    logic [3:0] slot_cnt;
    word_t      ir;
    word_t      dr;         // Operand bits, consumed from bit 0
    paddr_t     next_pa;
    paddr_t     cur_pa;
    paddr_t     ret_pa;
    paddr_t     jump_pa;
    subop_t     sub;
    logic       need_fetch;
    logic       fetch_cyc;
    logic       data_cyc;
    logic       fetch_done;
    logic       jump_taken;
    logic       is_call;
    logic       is_ret;

    assign need_fetch = slot_cnt == 4'd0 || slot_cnt > pkt_slots(ir) || slot_cnt > `SLOT_MAX;
    assign fetch_cyc  = run && need_fetch;
    assign fetch_done = fetch_cyc && ack_i;

    assign slot.slot_valid = run && !need_fetch;
    assign slot.opcode     = slot.slot_valid ? pkt_opcode(ir, slot_cnt) : OP_NOP;
    assign slot.operand    = dr;
    assign slot.rdata      = dat_i;
    assign slot.commit     = slot.slot_valid && (!slot.mem_req || ack_i);

    // **********************************************************
    // Bus master, fetch has priority over data
    // **********************************************************
    assign data_cyc = slot.slot_valid && slot.mem_req;
    assign cyc_o    = fetch_cyc || data_cyc;
    assign vpa_o    = fetch_cyc;
    assign we_o     = data_cyc && slot.mem_we;
    assign adr_o    = fetch_cyc ? next_pa : slot.mem_adr;
    assign dat_o    = we_o ? slot.mem_wdat : '0;

    // Offsets count packets from the start of the current one
    assign sub     = dr[3:0];
    assign jump_pa = cur_pa + paddr_t'(dr[11:4]);

    always_comb begin
        jump_taken = 1'b0;
        is_call    = 1'b0;
        is_ret     = 1'b0;
        case (slot.opcode)
            OP_JUMPS: begin
                case (sub)
                    SUB_JT8:  jump_taken = slot.tos_nonzero;
                    SUB_JF8:  jump_taken = !slot.tos_nonzero;
                    SUB_J8:   jump_taken = 1'b1;
                    SUB_CALL8: begin
                        jump_taken = 1'b1;
                        is_call    = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_RET: is_ret = 1'b1;
            default: ;
        endcase
    end

    operand_stack #(.T(paddr_t)) u_ret_stack (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .push_i(slot.commit && is_call),
        .pop_i (slot.commit && is_ret),
        .pop2_i(1'b0),
        .dat_i (next_pa),       // Return to the packet after the caller
        .top_o (ret_pa),
        .next_o()
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run      <= 1'b0;
            slot_cnt <= 4'd0;
            next_pa  <= `RESET_VECTOR;
        end else begin
            run <= 1'b1;
            if (fetch_done) begin
                next_pa  <= next_pa + 1'b1;
                slot_cnt <= 4'd1;
            end else if (slot.commit) begin
                if (is_ret) begin
                    next_pa  <= ret_pa;
                    slot_cnt <= 4'd0;
                end else if (jump_taken) begin
                    next_pa  <= jump_pa;
                    slot_cnt <= 4'd0;
                end else begin
                    slot_cnt <= slot_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_done) begin
            ir     <= dat_i;
            dr     <= dat_i;
            cur_pa <= next_pa;
        end else if (slot.commit) begin
            dr <= dr >> operand_len(slot.opcode);
        end
    end

    a_bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        cyc_o && !ack_i |=> cyc_o && $stable(adr_o) && $stable(we_o)
                            && $stable(vpa_o) && $stable(dat_o));

endmodule

/* logic/exec_unit.sv */
`include "core_params.svh"

module exec_unit
    import core_pkg::*, isa_pkg::*;
(
    input  logic clk_i,
    input  logic rst_i,
    slot_if.exec slot
);
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_LIT,
        ACT_BIN,
        ACT_STORE,
        ACT_LOAD,
        ACT_DROP
    } act_t;

    word_t   x;
    word_t   y;
    word_t   z;     // Top of stack
    word_t   lit;
    word_t   alu_res;
    word_t   ds_top;
    word_t   ds_next;
    alu_op_t alu_op;
    act_t    act;
    subop_t  sub;
    logic    ds_push;
    logic    ds_pop;
    logic    ds_pop2;

    assign sub = slot.operand[3:0];

    // **********************************************************
    // Slot decode
    // **********************************************************
    always_comb begin
        act    = ACT_NONE;
        alu_op = ALU_ADD;
        lit    = '0;
        case (slot.opcode)
            OP_LIT8: begin
                act = ACT_LIT;
                lit = word_t'($signed(slot.operand[7:0]));
            end
            OP_LIT16: begin
                act = ACT_LIT;
                lit = word_t'($signed(slot.operand[15:0]));
            end
            OP_LIT32: begin
                act = ACT_LIT;
                lit = word_t'($signed(slot.operand[31:0]));
            end
            OP_STORES: if (sub == SUB_SDM) act = ACT_STORE;
            OP_LOADS:  if (sub == SUB_LDM) act = ACT_LOAD;
            OP_INTOPS: begin
                act = ACT_BIN;
                case (sub)
                    SUB_ADD:  alu_op = ALU_ADD;
                    SUB_SUB:  alu_op = ALU_SUB;
                    SUB_SLT:  alu_op = ALU_SLT;
                    SUB_SLTU: alu_op = ALU_SLTU;
                    SUB_SEQ:  alu_op = ALU_SEQ;
                    SUB_XOR:  alu_op = ALU_XOR;
                    SUB_OR:   alu_op = ALU_OR;
                    SUB_AND:  alu_op = ALU_AND;
                    default:  act = ACT_NONE;
                endcase
            end
            // Only the conditional jumps consume their flag
            OP_JUMPS: if (sub == SUB_JT8 || sub == SUB_JF8) act = ACT_DROP;
            default: act = ACT_NONE;
        endcase
    end

    assign slot.mem_req     = slot.slot_valid && (act == ACT_STORE || act == ACT_LOAD);
    assign slot.mem_we      = act == ACT_STORE;
    assign slot.mem_adr     = z[`WORD_W-1:3];
    assign slot.mem_wdat    = y;
    assign slot.tos_nonzero = |z;

    assign ds_push = slot.commit && act == ACT_LIT;
    assign ds_pop  = slot.commit && (act == ACT_BIN || act == ACT_DROP);
    assign ds_pop2 = slot.commit && act == ACT_STORE;

    alu u_alu (
        .a_i  (y),
        .b_i  (z),
        .op_i (alu_op),
        .res_o(alu_res)
    );

    operand_stack #(.T(word_t)) u_data_stack (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .push_i(ds_push),
        .pop_i (ds_pop),
        .pop2_i(ds_pop2),
        .dat_i (x),
        .top_o (ds_top),
        .next_o(ds_next)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            x <= '0;
            y <= '0;
            z <= '0;
        end else if (slot.commit) begin
            case (act)
                ACT_LIT: begin
                    x <= y;
                    y <= z;
                    z <= lit;
                end
                ACT_BIN: begin
                    x <= ds_top;
                    y <= x;
                    z <= alu_res;
                end
                ACT_STORE: begin   // Address and data both leave the stack
                    x <= ds_next;
                    y <= ds_top;
                    z <= x;
                end
                ACT_LOAD: z <= slot.rdata;
                ACT_DROP: begin
                    x <= ds_top;
                    y <= x;
                    z <= y;
                end
                default: ;
            endcase
        end
    end

    // A data access waiting for ack keeps its address and data registers
    a_hold_on_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        slot.mem_req && !slot.commit |=> $stable(x) && $stable(y) && $stable(z));

endmodule

/* logic/alu.sv */
`include "core_params.svh"

module alu
    import core_pkg::*;
(
    input  word_t   a_i,
    input  word_t   b_i,
    input  alu_op_t op_i,
    output word_t   res_o
);
    logic  carry;
    logic  ovf;
    logic  lt_s;
    word_t diff;

    // One subtractor serves SUB and all three compares
    assign {carry, diff} = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;

    assign ovf  = (a_i[`WORD_W-1] ^ b_i[`WORD_W-1]) & (a_i[`WORD_W-1] ^ diff[`WORD_W-1]);
    assign lt_s = diff[`WORD_W-1] ^ ovf;

    always_comb begin
        res_o = '0;
        case (op_i)
            ALU_ADD:  res_o = a_i + b_i;
            ALU_SUB:  res_o = diff;
            ALU_XOR:  res_o = a_i ^ b_i;
            ALU_OR:   res_o = a_i | b_i;
            ALU_AND:  res_o = a_i & b_i;
            ALU_SLT:  res_o = word_t'(lt_s);
            ALU_SLTU: res_o = word_t'(!carry);    // No carry out means a borrow
            ALU_SEQ:  res_o = word_t'(diff == '0);
            default:  res_o = '0;
        endcase
    end

endmodule

/* logic/operand_stack.sv */
`include "core_params.svh"

module operand_stack
    import core_pkg::*;
#(
    parameter type T = word_t
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  logic pop_i,
    input  logic pop2_i,
    input  T     dat_i,
    output T     top_o,
    output T     next_o
);
    localparam int DEPTH = `STACK_DEPTH;

    T cells [DEPTH];

    assign top_o  = cells[0];
    assign next_o = cells[1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++)
                cells[i] <= '0;
        end else if (push_i) begin
            cells[0] <= dat_i;  // Deepest cell falls off the end
            for (int i = 1; i < DEPTH; i++)
                cells[i] <= cells[i-1];
        end else if (pop2_i) begin
            for (int i = 0; i < DEPTH; i++)
                cells[i] <= cells[(i + 2 < DEPTH) ? i + 2 : DEPTH - 1];
        end else if (pop_i) begin
            // Bottom cell repeats when the stack runs dry
            for (int i = 0; i < DEPTH; i++)
                cells[i] <= cells[(i + 1 < DEPTH) ? i + 1 : DEPTH - 1];
        end
    end

    a_no_push_pop: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !(pop_i || pop2_i));

endmodule

/* logic/slot_if.sv */
interface slot_if
    import core_pkg::*, isa_pkg::*;
();
    logic    slot_valid;
    opcode_t opcode;
    word_t   operand;
    logic    commit;    // Current slot retires at this edge
    word_t   rdata;

    logic    mem_req;
    logic    mem_we;
    paddr_t  mem_adr;
    word_t   mem_wdat;
    logic    tos_nonzero;

    modport seq (
        output slot_valid, opcode, operand, commit, rdata,
        input  mem_req, mem_we, mem_adr, mem_wdat, tos_nonzero
    );

    modport exec (
        input  slot_valid, opcode, operand, commit, rdata,
        output mem_req, mem_we, mem_adr, mem_wdat, tos_nonzero
    );

endinterface

/* logic/isa_pkg.sv */
`include "core_params.svh"

package isa_pkg;
    import core_pkg::*;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_LIT8   = 4'd1,
        OP_LIT16  = 4'd2,
        OP_LIT32  = 4'd3,
        OP_STORES = 4'd4,
        OP_LOADS  = 4'd5,
        OP_INTOPS = 4'd6,
        OP_JUMPS  = 4'd7,
        OP_RET    = 4'd8
    } opcode_t;

    // Sub-operations share codes across opcode groups
    typedef logic [3:0] subop_t;

    localparam subop_t SUB_SDM   = 4'd3;
    localparam subop_t SUB_LDM   = 4'd3;
    localparam subop_t SUB_ADD   = 4'd0;
    localparam subop_t SUB_SUB   = 4'd1;
    localparam subop_t SUB_SLT   = 4'd3;
    localparam subop_t SUB_SLTU  = 4'd4;
    localparam subop_t SUB_SEQ   = 4'd7;
    localparam subop_t SUB_XOR   = 4'd9;
    localparam subop_t SUB_OR    = 4'd12;
    localparam subop_t SUB_AND   = 4'd13;
    localparam subop_t SUB_JT8   = 4'd0;
    localparam subop_t SUB_JF8   = 4'd1;
    localparam subop_t SUB_J8    = 4'd2;
    localparam subop_t SUB_CALL8 = 4'd3;

    // Operand bits consumed by one slot
    function automatic logic [5:0] operand_len(opcode_t op);
        case (op)
            OP_LIT8:   return 6'd8;
            OP_LIT16:  return 6'd16;
            OP_LIT32:  return 6'd32;
            OP_STORES: return 6'd4;
            OP_LOADS:  return 6'd4;
            OP_INTOPS: return 6'd4;
            OP_JUMPS:  return 6'd12;
            default:   return 6'd0;
        endcase
    endfunction

    function automatic logic [3:0] pkt_slots(word_t pkt);
        return pkt[`WORD_W-1 -: 4];
    endfunction

    // Slot 1 sits just below the slot count
    function automatic opcode_t pkt_opcode(word_t pkt, logic [3:0] slot);
        if (slot == 4'd0 || slot > `SLOT_MAX)
            return OP_NOP;
        return opcode_t'(pkt[`WORD_W - 1 - 4 * slot -: 4]);
    endfunction

endpackage

/* logic/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    // One machine word
    typedef logic [`WORD_W-1:0] word_t;

    // Packets are whole words, so the low three byte-address bits are dropped
    typedef logic [`WORD_W-4:0] paddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_SEQ
    } alu_op_t;

endpackage

/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Machine word, also the instruction packet width
`define WORD_W 64

// Cells below the register top of stack, and return stack depth
`define STACK_DEPTH 4

// Opcode slots in one packet
`define SLOT_MAX 7

// Packet (word) address of the first fetch, byte address 64'hE000_0000_0000_0000
`define RESET_VECTOR 61'h1C00_0000_0000_0000

`endif
